// File: verif/rx_frames_input.txt
# F outcome payload_length | W ctl data, hex with lane 3 leftmost | P payload bytes in hex
# Outcome is commit, drop or none, FCS words computed offline
F commit 8
W 8 fb555555
W 0 555555d5
W 0 ffffffff
W 0 00000000
W 0 ffffffff
W f fd070707
P ff ff ff ff 00 00 00 00
F commit 9
W 8 fb555555
W 0 555555d5
W 0 31323334
W 0 35363738
W 0 392639f4
W 7 cbfd0707
P 31 32 33 34 35 36 37 38 39
F commit 14
W 8 fb555555
W 0 555555d5
W 0 6d657373
W 0 61676520
W 0 64696765
W 0 73747f9d
W 3 1520fd07
P 6d 65 73 73 61 67 65 20 64 69 67 65 73 74
F drop 0
W 8 fb555555
W 0 555555d5
W 0 31323334
W 0 35363738
W 0 392639f4
W 7 cafd0707
P
F commit 3
W 8 fb555555
W 0 555555d5
W 0 616263c2
W 1 412435fd
P 61 62 63
F drop 0
W 8 fb555555
W 0 555555d5
W 0 61626364
W 2 6566fe68
P
F none 0
W 8 fb555555
W 0 55555555
W 0 01020304
W f fd070707
P
F commit 4
W 8 fb555555
W 0 555555d5
W 0 ffffffff
W 0 ffffffff
W f fd070707
P ff ff ff ff

// File: vlog.f
hdl/xg_mac_pkg.sv
hdl/crc32_ethernet_x32.sv
hdl/xg_fcs_checker.sv
hdl/xg_rx_framer.sv
hdl/xg_mac_rx.sv
verif/xg_mac_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the receive MAC testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module xg_mac_rx_tb -f vlog.f \
	|| { echo "Verilator build failed"; exit 1; }
result=$(./obj_dir/Vxg_mac_rx_tb)
echo "$result"
echo "$result" | grep -qx "No errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: verif/xg_mac_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xg_mac_rx_tb import xg_mac_pkg::*; ();

	localparam string input_file = "verif/rx_frames_input.txt";
	localparam int    wait_limit = 200;

	logic        xgmii_rx_clk;
	logic        reset;
	xgmii_word_t xgmii_rx;
	eth_rx_bus_t rx_bus;

	// Running event counts from the monitor
	int          start_count  = 0;
	int          commit_count = 0;
	int          drop_count   = 0;
	int          data_count   = 0;
	byte_count_t last_bytes   = '0;
	logic [7:0]  payload [$];
	logic [7:0]  expected [$];
	int          mismatches   = 0;
	int          failures     = 0;

	xg_mac_rx i_xg_mac_rx (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.xgmii_rx     (xgmii_rx),
		.rx_bus       (rx_bus)
	);

	// 40 ns period
	initial begin
		xgmii_rx_clk = 1'b0;
		forever #20 xgmii_rx_clk = ~xgmii_rx_clk;
	end

	////////////////////
	// Output monitor

	// Sampled on the falling edge while the outputs are stable
	always @(negedge xgmii_rx_clk) begin
		if (!reset) begin
			// New frame drops what was gathered before
			if (rx_bus.start) begin
				start_count++;
				payload.delete();
			end
			// Leftmost bytes_valid bytes are payload
			if (rx_bus.data_valid) begin
				data_count++;
				last_bytes = rx_bus.bytes_valid;
				for (int i = 0; i < int'(rx_bus.bytes_valid); i++) begin
					payload.push_back(rx_bus.data[31-8*i -: 8]);
				end
			end
			commit_count += int'(rx_bus.commit);
			drop_count   += int'(rx_bus.drop);
		end
	end

	////////////////////
	// Stimulus helpers

	// Inputs move 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge xgmii_rx_clk);
		#2;
	endtask

	// Random valid-low words first that repeat the last word
	task automatic send_word(input logic [3:0] ctl, input logic [31:0] data);
		int gap;
		gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
		repeat (gap) begin
			xgmii_rx.valid = 1'b0;
			next_cycle();
		end
		xgmii_rx = '{valid: 1'b1, ctl: ctl, data: data};
		next_cycle();
	endtask

	task automatic send_idle();
		send_word(4'hf, {4{xgmii_ctl_idle}});
	endtask

	task automatic compare_value(input string name, input int exp_value, input int act_value);
		assert (exp_value == act_value) else begin
			$display("mismatch at %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, exp_value, act_value);
			mismatches++;
		end
	endtask

	////////////////////
	// Per-frame check

	// Idles keep the pipeline moving until the verdict shows up
	task automatic check_frame(input string outcome, input int starts0,
		input int commits0, input int drops0);
		int cycles;
		int exp_last;
		cycles = 0;
		if (outcome != "none") begin
			while ((commit_count + drop_count == commits0 + drops0) && (cycles < wait_limit)) begin
				send_idle();
				cycles++;
			end
			assert (cycles < wait_limit) else begin
				$display("timeout at %0t: no commit or drop after the frame", $time);
				failures++;
			end
		end

		// Room for a stray second verdict to appear
		repeat (6) send_idle();

		compare_value("rx_bus.start", 1, start_count - starts0);
		compare_value("rx_bus.commit", int'(outcome == "commit"), commit_count - commits0);
		compare_value("rx_bus.drop", int'(outcome == "drop"), drop_count - drops0);

		if (outcome == "commit") begin
			compare_value("payload length", expected.size(), payload.size());
			for (int i = 0; (i < expected.size()) && (i < payload.size()); i++) begin
				compare_value($sformatf("payload byte %0d", i), int'(expected[i]),
					int'(payload[i]));
			end
			// Last word carries what is left after whole words
			exp_last = (expected.size() % 4 == 0) ? 4 : expected.size() % 4;
			compare_value("rx_bus.bytes_valid", exp_last, int'(last_bytes));
		end
	endtask

	task automatic finish_run();
		$display("mismatches: %0d, other failures: %0d", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	////////////////////
	// Main sequence

	initial begin
		int          fd;
		int          code;
		int          exp_len;
		int          gap;
		int          starts0;
		int          commits0;
		int          drops0;
		logic [3:0]  ctl;
		logic [31:0] data;
		logic [7:0]  value;
		string       outcome;
		string       line;

		void'($urandom(32'h414f277c));
		exp_len  = 0;
		outcome  = "none";
		starts0  = 0;
		commits0 = 0;
		drops0   = 0;
		xgmii_rx = '{valid: 1'b0, ctl: 4'hf, data: {4{xgmii_ctl_idle}}};
		reset    = 1'b1;
		repeat (10) @(posedge xgmii_rx_clk);
		#2;
		reset = 1'b0;

		// Only idles here and the bus must stay quiet
		repeat (8) send_idle();
		compare_value("rx_bus.start", 0, start_count);
		compare_value("rx_bus.data_valid", 0, data_count);
		compare_value("rx_bus.commit", 0, commit_count);
		compare_value("rx_bus.drop", 0, drop_count);

		fd = $fopen(input_file, "r");
		assert (fd != 0) else begin
			$display("could not open the stimulus file %s", input_file);
			failures++;
		end
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if ((code > 0) && (line.len() > 1)) begin
					if (line.getc(0) == "F") begin
						// Frame header with a random idle gap before the frame
						code = $sscanf(line, "F %s %d", outcome, exp_len);
						expected.delete();
						gap = int'($urandom % 4) + 1;
						repeat (gap) send_idle();
						starts0  = start_count;
						commits0 = commit_count;
						drops0   = drop_count;
					end else if (line.getc(0) == "W") begin
						code = $sscanf(line, "W %h %h", ctl, data);
						send_word(ctl, data);
					end else if (line.getc(0) == "P") begin
						// Two hex digits per byte with one space between
						for (int i = 0; i < exp_len; i++) begin
							code = $sscanf(line.substr(2 + 3*i, 3 + 3*i), "%h", value);
							expected.push_back(value);
						end
						check_frame(outcome, starts0, commits0, drops0);
					end
				end
			end
			$fclose(fd);
		end

		finish_run();
	end

endmodule

`default_nettype wire

// File: hdl/xg_mac_rx.sv
`timescale 1ns/1ps
`default_nettype none

module xg_mac_rx import xg_mac_pkg::*; #(
	// CRC pipeline depth, shared by the engine and the checker
	parameter int crc_latency = 2
) (
	input  logic        xgmii_rx_clk,
	input  logic        reset,
	input  xgmii_word_t xgmii_rx,
	output eth_rx_bus_t rx_bus
);

	eth_rx_bus_t frame_out;
	fcs_word_t   fcs_report;
	logic [31:0] crc_value;
	logic        commit;
	logic        drop;

	////////////////////
	// Framing

	xg_rx_framer i_xg_rx_framer (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.xgmii_rx     (xgmii_rx),
		.frame_out    (frame_out),
		.fcs_report   (fcs_report)
	);

	////////////////////
	// Checksum

	// Fed with exactly the payload bytes the upper layer sees
	crc32_ethernet_x32 #(
		.crc_latency (crc_latency)
	) i_crc32_ethernet_x32 (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.clear        (frame_out.start),
		.advance      (xgmii_rx.valid),
		.din_len      (frame_out.bytes_valid),
		.din          (frame_out.data),
		.crc_value    (crc_value)
	);

	xg_fcs_checker #(
		.crc_latency (crc_latency)
	) i_xg_fcs_checker (
		.xgmii_rx_clk (xgmii_rx_clk),
		.reset        (reset),
		.advance      (xgmii_rx.valid),
		.fcs_report   (fcs_report),
		.crc_value    (crc_value),
		.commit       (commit),
		.drop         (drop)
	);

	// Data fields from the framer, verdict from the checker
	always_comb begin
		rx_bus        = frame_out;
		rx_bus.commit = commit;
		rx_bus.drop   = drop;
	end

endmodule

`default_nettype wire

// File: hdl/xg_rx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module xg_rx_framer import xg_mac_pkg::*; (
	input  logic        xgmii_rx_clk,
	input  logic        reset,
	input  xgmii_word_t xgmii_rx,
	output eth_rx_bus_t frame_out,
	output fcs_word_t   fcs_report
);

	////////////////////
	// Lane decoding

	logic [xgmii_lanes-1:0] lane_has_end;
	logic [xgmii_lanes-1:0] lane_has_error;
	logic                   start_detect;

	// End and Error may show up in any lane
	always_comb begin
		for (int i = 0; i < xgmii_lanes; i++) begin
			lane_has_end[i]   = xgmii_rx.ctl[i] && (xgmii_rx.data[8*i +: 8] == xgmii_ctl_end);
			lane_has_error[i] = xgmii_rx.ctl[i] && (xgmii_rx.data[8*i +: 8] == xgmii_ctl_error);
		end
	end

	// Start is only legal in the leftmost lane
	assign start_detect = xgmii_rx.ctl[3] && (xgmii_rx.data[31:24] == xgmii_ctl_start);

	////////////////////
	// Receive FSM

	rx_state_t   rx_state;
	logic        last_was_preamble;
	logic        start_q;
	logic [31:0] held_data;
	logic        preamble_ok;

	// Exactly one all-data word 55 55 55 D5 after Start
	assign preamble_ok = (xgmii_rx.ctl == 4'b0000) && (xgmii_rx.data == xgmii_preamble_sfd);

	always_ff @(posedge xgmii_rx_clk) begin
		// start is a single-clock strobe
		start_q <= 1'b0;

		if (reset) begin
			rx_state          <= rx_idle;
			last_was_preamble <= 1'b0;
		end else if (xgmii_rx.valid) begin
			last_was_preamble <= 1'b0;

			case (rx_state)
				// Idles and stray errors are ignored here
				rx_idle: begin
					if (start_detect) begin
						rx_state <= rx_preamble;
					end
				end

				// Announce the frame one word early, even if the preamble is bad
				rx_preamble: begin
					start_q           <= 1'b1;
					last_was_preamble <= 1'b1;
					if (preamble_ok) begin
						rx_state <= rx_body;
					end else begin
						rx_state <= rx_idle;
					end
				end

				// End can land in any lane
				rx_body: begin
					if (|lane_has_end) begin
						rx_state <= rx_idle;
					end
				end

				default: begin
					rx_state <= rx_idle;
				end
			endcase

			// Error inside a frame wins over everything else
			if ((|lane_has_error) && (rx_state != rx_idle)) begin
				rx_state <= rx_idle;
			end
		end
	end

	// One-word holdback so the FCS never reaches the upper layer
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx.valid) begin
			held_data <= xgmii_rx.data;
		end
	end

	////////////////////
	// Output words and FCS splice

	logic        body_word;
	logic        data_valid;
	byte_count_t bytes_valid;
	logic [31:0] fcs_value;
	logic        fcs_end;
	logic        abort;

	assign body_word = xgmii_rx.valid && (rx_state == rx_body);

	always_comb begin
		data_valid  = 1'b0;
		bytes_valid = '0;
		fcs_value   = held_data;
		fcs_end     = 1'b0;

		if (body_word) begin
			if (lane_has_end[3]) begin
				// Held word is the whole FCS, nothing left for the upper layer
				fcs_value = held_data;
			end else if (lane_has_end[2]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd1;
				fcs_value   = {held_data[23:0], xgmii_rx.data[31:24]};
			end else if (lane_has_end[1]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd2;
				fcs_value   = {held_data[15:0], xgmii_rx.data[31:16]};
			end else if (lane_has_end[0]) begin
				data_valid  = 1'b1;
				bytes_valid = 3'd3;
				fcs_value   = {held_data[7:0], xgmii_rx.data[31:8]};
			end else if (!last_was_preamble) begin
				// Mid-frame, held word is plain payload
				// First body word still holds the SFD, skip it
				data_valid  = 1'b1;
				bytes_valid = 3'd4;
			end

			// Clean end only, an error on the same word turns it into an abort
			fcs_end = (|lane_has_end) && !(|lane_has_error);
		end
	end

	// Abort anywhere between Start and End
	assign abort = xgmii_rx.valid && (rx_state != rx_idle) && (|lane_has_error);

	////////////////////
	// Output assembly

	// commit and drop come from the checker at the top level
	assign frame_out = '{
		start:       start_q,
		data_valid:  data_valid,
		bytes_valid: bytes_valid,
		data:        held_data,
		commit:      1'b0,
		drop:        1'b0
	};

	assign fcs_report = '{
		fcs_end: fcs_end,
		abort:   abort,
		fcs:     fcs_value
	};

endmodule

`default_nettype wire

// File: hdl/xg_fcs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module xg_fcs_checker import xg_mac_pkg::*; #(
	// Must match the CRC engine depth
	parameter int crc_latency = 2
) (
	input  logic        xgmii_rx_clk,
	input  logic        reset,
	input  logic        advance,
	input  fcs_word_t   fcs_report,
	input  logic [31:0] crc_value,
	output logic        commit,
	output logic        drop
);

	////////////////////
	// Expected FCS delay line

	logic [crc_latency-1:0]     pending;
	logic [8*xgmii_lanes-1:0]   fcs_pipe [crc_latency];
	logic                       fcs_match;

	// Received FCS follows the CRC through the same number of valid words
	always_ff @(posedge xgmii_rx_clk) begin
		if (advance) begin
			fcs_pipe[0] <= fcs_report.fcs;
			for (int k = 1; k < crc_latency; k++) begin
				fcs_pipe[k] <= fcs_pipe[k-1];
			end
		end
	end

	assign fcs_match = (fcs_pipe[crc_latency-1] == crc_value);

	////////////////////
	// Verdict

	always_ff @(posedge xgmii_rx_clk) begin
		// Both verdicts are one-clock strobes
		commit <= 1'b0;
		drop   <= 1'b0;

		if (reset) begin
			pending <= '0;
		end else if (advance) begin
			// Pending flag walks alongside its FCS
			pending[0] <= fcs_report.fcs_end;
			for (int k = 1; k < crc_latency; k++) begin
				pending[k] <= pending[k-1];
			end

			// CRC of the last bytes has just arrived
			if (pending[crc_latency-1]) begin
				if (fcs_match) begin
					commit <= 1'b1;
				end else begin
					drop <= 1'b1;
				end
			end

			// Error character kills the frame and anything in flight
			if (fcs_report.abort) begin
				pending <= '0;
				commit  <= 1'b0;
				drop    <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc32_ethernet_x32.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_ethernet_x32 import xg_mac_pkg::*; #(
	// Stages from din to crc_value, at least 1
	parameter int crc_latency = 2
) (
	input  logic        xgmii_rx_clk,
	input  logic        reset,
	input  logic        clear,
	input  logic        advance,
	input  byte_count_t din_len,
	input  logic [31:0] din,
	output logic [31:0] crc_value
);

	////////////////////
	// CRC math

	// 04C11DB7 bit-reversed, for the LSB-first shift
	localparam logic [31:0] crc_poly_reflected = 32'hedb8_8320;
	localparam logic [31:0] crc_init           = 32'hffff_ffff;

	// Leftmost byte goes in first, each byte LSB first as on the wire
	function automatic logic [31:0] crc_update(
		input logic [31:0] crc_in,
		input logic [31:0] data,
		input byte_count_t len
	);
		logic [31:0] crc;
		logic [7:0]  data_byte;
		crc = crc_in;
		for (int i = 0; i < xgmii_lanes; i++) begin
			data_byte = data[8*(xgmii_lanes-1-i) +: 8];
			// Only the leftmost len bytes count
			if (i < int'(len)) begin
				for (int b = 0; b < 8; b++) begin
					if (crc[0] ^ data_byte[b]) begin
						crc = (crc >> 1) ^ crc_poly_reflected;
					end else begin
						crc = crc >> 1;
					end
				end
			end
		end
		return crc;
	endfunction

	// Final inversion, then bytes in the order they sit on XGMII
	// Low byte of the FCS is transmitted first, so it ends up leftmost
	function automatic logic [31:0] crc_to_wire(input logic [31:0] crc);
		logic [31:0] fcs;
		fcs = ~crc;
		return {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
	endfunction

	////////////////////
	// Pipeline

	// Stage 0 is the running remainder, later stages just delay it
	logic [31:0] crc_pipe [crc_latency];

	always_ff @(posedge xgmii_rx_clk) begin
		// Seed on reset and on every frame start
		if (reset || clear) begin
			crc_pipe[0] <= crc_init;
		end else if (advance) begin
			crc_pipe[0] <= crc_update(crc_pipe[0], din, din_len);
		end

		// Delay stages move in step with the valid words
		if (advance) begin
			for (int k = 1; k < crc_latency; k++) begin
				crc_pipe[k] <= crc_pipe[k-1];
			end
		end
	end

	// Result in wire order, ready to compare against the received FCS
	assign crc_value = crc_to_wire(crc_pipe[crc_latency-1]);

endmodule

`default_nettype wire

// File: hdl/xg_mac_pkg.sv
`default_nettype none

package xg_mac_pkg;

	////////////////////
	// XGMII constants

	// Byte lanes per XGMII word, lane 3 is leftmost
	localparam int xgmii_lanes = 4;

	// Control characters, valid only where the lane's ctl bit is set
	localparam logic [7:0] xgmii_ctl_start = 8'hfb;
	localparam logic [7:0] xgmii_ctl_end   = 8'hfd;
	localparam logic [7:0] xgmii_ctl_error = 8'hfe;
	localparam logic [7:0] xgmii_ctl_idle  = 8'h07;

	// Rest of the preamble plus SFD, the only word allowed after Start
	localparam logic [31:0] xgmii_preamble_sfd = 32'h55_55_55_d5;

	////////////////////
	// Bus types

	// Number of valid bytes in a word, 0 to 4
	typedef logic [2:0] byte_count_t;

	// One receive word as it comes off the PCS
	typedef struct packed {
		logic        valid;
		logic [3:0]  ctl;
		logic [31:0] data;
	} xgmii_word_t;

	// Upper-layer stream, act on data only after commit
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
	} eth_rx_bus_t;

	// Framer to checker, FCS in wire order plus end/abort strobes
	typedef struct packed {
		logic        fcs_end;
		logic        abort;
		logic [31:0] fcs;
	} fcs_word_t;

	// Receive FSM
	typedef enum logic [1:0] {
		rx_idle     = 2'd0,
		rx_preamble = 2'd1,
		rx_body     = 2'd2
	} rx_state_t;

endpackage

`default_nettype wire
